// ==== eai_pkg.sv ====
`default_nettype none

package eai_pkg;

   //////////////////////////////
   // widths and sizes
   //////////////////////////////
   localparam int XLEN      = 32;
   localparam int ROW_WORDS = 3;

   // custom-0 major opcode
   localparam logic [6:0] OPC_CUSTOM0 = 7'b0001011;

   localparam logic [2:0] F3_SETUP  = 3'b011;
   localparam logic [2:0] F3_SUM    = 3'b110;

   localparam logic [6:0] F7_SETUP  = 7'b0000000;
   localparam logic [6:0] F7_ROWSUM = 7'b0000001;
   localparam logic [6:0] F7_COLSUM = 7'b0000010;

   //////////////////////////////
   // payloads
   //////////////////////////////
   typedef enum logic [1:0] {
      OP_NONE   = 2'd0,
      OP_SETUP  = 2'd1,
      OP_ROWSUM = 2'd2,
      OP_COLSUM = 2'd3
   } eai_op_t;

   typedef struct packed {
      logic [XLEN-1:0] inst;
      logic [XLEN-1:0] rs1;
      logic [XLEN-1:0] rs2;
   } eai_req_t;

   typedef struct packed {
      eai_op_t         op;
      logic [XLEN-1:0] rs1;
      logic [XLEN-1:0] rs2;
   } eai_cmd_t;

   // word reads only
   typedef struct packed {
      logic [XLEN-1:0] addr;
   } icb_cmd_t;

   typedef struct packed {
      logic [XLEN-1:0] rdata;
   } icb_rsp_t;

endpackage

`default_nettype wire

// ==== eai_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module eai_decode
   import eai_pkg::*;
(
   input  logic     eai_clk,
   input  logic     arst_n,
   input  logic     req_valid,
   input  eai_req_t req,
   output logic     req_ready,
   input  logic     busy,
   output logic     cmd_valid,
   output eai_cmd_t cmd
);

   logic [6:0] opcode;
   logic [2:0] func3;
   logic [6:0] func7;
   eai_op_t    req_op;
   logic       accept;

   assign opcode = req.inst[6:0];
   assign func3  = req.inst[14:12];
   assign func7  = req.inst[31:25];

   // anything else on custom-0 falls through as OP_NONE
   always_comb begin
      req_op = OP_NONE;
      if (opcode == OPC_CUSTOM0) begin
         if ((func3 == F3_SETUP) && (func7 == F7_SETUP)) begin
            req_op = OP_SETUP;
         end else if ((func3 == F3_SUM) && (func7 == F7_ROWSUM)) begin
            req_op = OP_ROWSUM;
         end else if ((func3 == F3_SUM) && (func7 == F7_COLSUM)) begin
            req_op = OP_COLSUM;
         end
      end
   end

   assign req_ready = ~busy;
   assign accept    = req_valid & req_ready;

   // one-cycle strobe toward execute
   always_ff @(posedge eai_clk or negedge arst_n) begin
      if (!arst_n) begin
         cmd_valid <= 1'b0;
      end else begin
         cmd_valid <= accept && (req_op != OP_NONE);
      end
   end

   always_ff @(posedge eai_clk) begin
      if (accept) begin
         cmd.op  <= req_op;
         cmd.rs1 <= req.rs1;
         cmd.rs2 <= req.rs2;
      end
   end

endmodule

`default_nettype wire

// ==== eai_execute.sv ====
`timescale 1ns/10ps
`default_nettype none

module eai_execute
   import eai_pkg::*;
(
   input  logic            eai_clk,
   input  logic            arst_n,
   input  logic            cmd_valid,
   input  eai_cmd_t        cmd,
   output logic            busy,
   output logic            icb_cmd_valid,
   input  logic            icb_cmd_ready,
   output icb_cmd_t        icb_cmd,
   input  logic            icb_rsp_valid,
   input  icb_rsp_t        icb_rsp,
   output logic            clear,
   output logic            row_first,
   output logic            word_valid,
   output logic [XLEN-1:0] word,
   output logic [1:0]      col_sel,
   output logic            sel_col,
   output logic            rsp_valid,
   input  logic            rsp_ready,
   output logic            mem_holdup
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_ISSUE,
      ST_WAIT,
      ST_RESP
   } state_t;

   state_t          state;
   logic [XLEN-1:0] base_r;
   logic [XLEN-1:0] len_r;
   logic [XLEN-1:0] addr_r;
   logic [XLEN-1:0] row_start;
   logic [1:0]      col_r;
   logic            row_first_r;
   logic            sel_col_r;
   logic            is_setup;
   logic            is_rowsum;
   logic            is_colsum;
   logic            rsp_word;
   logic            last_word;

   assign is_setup  = cmd_valid && (cmd.op == OP_SETUP);
   assign is_rowsum = cmd_valid && (cmd.op == OP_ROWSUM);
   assign is_colsum = cmd_valid && (cmd.op == OP_COLSUM);
   assign rsp_word  = (state == ST_WAIT) && icb_rsp_valid;
   assign last_word = (col_r == 2'(ROW_WORDS - 1));

   // byte address of word 0 in the requested row
   assign row_start = base_r + ((cmd.rs1 * len_r) << 2);

   //////////////////////////////
   // sequencer
   //////////////////////////////
   always_ff @(posedge eai_clk or negedge arst_n) begin
      if (!arst_n) begin
         state <= ST_IDLE;
      end else begin
         case (state)
            ST_IDLE: begin
               if (is_rowsum) begin
                  state <= ST_ISSUE;
               end else if (is_setup || is_colsum) begin
                  state <= ST_RESP;
               end
            end
            ST_ISSUE: begin
               if (icb_cmd_ready) begin
                  state <= ST_WAIT;
               end
            end
            ST_WAIT: begin
               if (icb_rsp_valid) begin
                  state <= last_word ? ST_RESP : ST_ISSUE;
               end
            end
            default: begin
               if (rsp_ready) begin
                  state <= ST_IDLE;
               end
            end
         endcase
      end
   end

   always_ff @(posedge eai_clk or negedge arst_n) begin
      if (!arst_n) begin
         base_r <= '0;
         len_r  <= '0;
      end else if (is_setup) begin
         base_r <= cmd.rs1;
         len_r  <= cmd.rs2;
      end
   end

   // col_r counts words during a row, holds the column for colsum
   always_ff @(posedge eai_clk or negedge arst_n) begin
      if (!arst_n) begin
         col_r       <= '0;
         sel_col_r   <= 1'b0;
         row_first_r <= 1'b0;
      end else if (is_rowsum) begin
         col_r       <= '0;
         sel_col_r   <= 1'b0;
         row_first_r <= (cmd.rs1 == '0);
      end else if (is_colsum) begin
         col_r     <= (cmd.rs1 < XLEN'(ROW_WORDS)) ? cmd.rs1[1:0] : 2'(ROW_WORDS);
         sel_col_r <= 1'b1;
      end else if (is_setup) begin
         // out of range entry, so setup answers zero
         col_r     <= 2'(ROW_WORDS);
         sel_col_r <= 1'b1;
      end else if (rsp_word) begin
         col_r <= col_r + 2'd1;
      end
   end

   always_ff @(posedge eai_clk) begin
      if (is_rowsum) begin
         addr_r <= row_start;
      end else if (rsp_word) begin
         addr_r <= addr_r + XLEN'(4);
      end
   end

   assign busy          = cmd_valid || (state != ST_IDLE);
   assign icb_cmd_valid = (state == ST_ISSUE);
   assign icb_cmd.addr  = addr_r;
   assign mem_holdup    = (state == ST_ISSUE) || (state == ST_WAIT);
   assign rsp_valid     = (state == ST_RESP);

   assign clear      = is_rowsum;
   assign row_first  = row_first_r;
   assign word_valid = rsp_word;
   assign word       = icb_rsp.rdata;
   assign col_sel    = col_r;
   assign sel_col    = sel_col_r;

endmodule

`default_nettype wire

// ==== eai_result.sv ====
`timescale 1ns/10ps
`default_nettype none

module eai_result
   import eai_pkg::*;
(
   input  logic            eai_clk,
   input  logic            arst_n,
   input  logic            clear,
   input  logic            row_first,
   input  logic            word_valid,
   input  logic [XLEN-1:0] word,
   input  logic [1:0]      col_sel,
   input  logic            sel_col,
   output logic [XLEN-1:0] rsp_rdat
);

   logic [XLEN-1:0] acc_r;
   logic [XLEN-1:0] col_buf [ROW_WORDS];
   logic [XLEN-1:0] col_dat;

   //////////////////////////////
   // row accumulator
   //////////////////////////////
   always_ff @(posedge eai_clk or negedge arst_n) begin
      if (!arst_n) begin
         acc_r <= '0;
      end else if (clear) begin
         acc_r <= '0;
      end else if (word_valid) begin
         // wraps modulo 2^32
         acc_r <= acc_r + word;
      end
   end

   //////////////////////////////
   // column buffer
   //////////////////////////////
   always_ff @(posedge eai_clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int k = 0; k < ROW_WORDS; k++) begin
            col_buf[k] <= '0;
         end
      end else if (word_valid) begin
         for (int k = 0; k < ROW_WORDS; k++) begin
            if (col_sel == 2'(k)) begin
               col_buf[k] <= row_first ? word : col_buf[k] + word;
            end
         end
      end
   end

   // zero for an entry past the buffer
   always_comb begin
      col_dat = '0;
      for (int k = 0; k < ROW_WORDS; k++) begin
         if (col_sel == 2'(k)) begin
            col_dat = col_buf[k];
         end
      end
   end

   assign rsp_rdat = sel_col ? col_dat : acc_r;

endmodule

`default_nettype wire

// ==== eai_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module eai_core
   import eai_pkg::*;
(
   input  logic            eai_clk,
   input  logic            arst_n,
   // request
   input  logic            req_valid,
   output logic            req_ready,
   input  eai_req_t        req,
   // response
   output logic            rsp_valid,
   input  logic            rsp_ready,
   output logic [XLEN-1:0] rsp_rdat,
   // memory read port
   output logic            icb_cmd_valid,
   input  logic            icb_cmd_ready,
   output icb_cmd_t        icb_cmd,
   input  logic            icb_rsp_valid,
   input  icb_rsp_t        icb_rsp,
   output logic            mem_holdup
);

   logic            cmd_valid;
   eai_cmd_t        cmd;
   logic            busy;
   logic            clear;
   logic            row_first;
   logic            word_valid;
   logic [XLEN-1:0] word;
   logic [1:0]      col_sel;
   logic            sel_col;

   eai_decode eai_decode_i (
      .eai_clk   (eai_clk),
      .arst_n    (arst_n),
      .req_valid (req_valid),
      .req       (req),
      .req_ready (req_ready),
      .busy      (busy),
      .cmd_valid (cmd_valid),
      .cmd       (cmd)
   );

   eai_execute eai_execute_i (
      .eai_clk       (eai_clk),
      .arst_n        (arst_n),
      .cmd_valid     (cmd_valid),
      .cmd           (cmd),
      .busy          (busy),
      .icb_cmd_valid (icb_cmd_valid),
      .icb_cmd_ready (icb_cmd_ready),
      .icb_cmd       (icb_cmd),
      .icb_rsp_valid (icb_rsp_valid),
      .icb_rsp       (icb_rsp),
      .clear         (clear),
      .row_first     (row_first),
      .word_valid    (word_valid),
      .word          (word),
      .col_sel       (col_sel),
      .sel_col       (sel_col),
      .rsp_valid     (rsp_valid),
      .rsp_ready     (rsp_ready),
      .mem_holdup    (mem_holdup)
   );

   eai_result eai_result_i (
      .eai_clk    (eai_clk),
      .arst_n     (arst_n),
      .clear      (clear),
      .row_first  (row_first),
      .word_valid (word_valid),
      .word       (word),
      .col_sel    (col_sel),
      .sel_col    (sel_col),
      .rsp_rdat   (rsp_rdat)
   );

endmodule

`default_nettype wire

// ==== eai_core_sva.sv ====
`timescale 1ns/10ps
`default_nettype none

module eai_core_sva
   import eai_pkg::*;
(
   input logic            eai_clk,
   input logic            arst_n,
   input logic            req_ready,
   input logic            rsp_valid,
   input logic            rsp_ready,
   input logic [XLEN-1:0] rsp_rdat,
   input logic            icb_cmd_valid,
   input logic            icb_cmd_ready,
   input icb_cmd_t        icb_cmd,
   input logic            mem_holdup
);

   int fail_count = 0;

   rsp_hold: assert property (@(posedge eai_clk) disable iff (!arst_n)
      rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_rdat))
   else begin
      fail_count++;
      $error("rsp_valid dropped or rsp_rdat changed before rsp_ready");
   end

   icb_cmd_hold: assert property (@(posedge eai_clk) disable iff (!arst_n)
      icb_cmd_valid && !icb_cmd_ready |=> icb_cmd_valid && $stable(icb_cmd.addr))
   else begin
      fail_count++;
      $error("icb_cmd_valid dropped or address changed before icb_cmd_ready");
   end

   // no new request while a response waits
   req_blocked: assert property (@(posedge eai_clk) disable iff (!arst_n)
      !(req_ready && rsp_valid))
   else begin
      fail_count++;
      $error("req_ready high while rsp_valid is high");
   end

   holdup_cover: assert property (@(posedge eai_clk) disable iff (!arst_n)
      icb_cmd_valid |-> mem_holdup)
   else begin
      fail_count++;
      $error("icb_cmd_valid high without mem_holdup");
   end

endmodule

`default_nettype wire

// ==== eai_core_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module eai_core_checker
   import eai_pkg::*;
(
   input  logic            eai_clk,
   input  logic            arst_n,
   input  logic            push,
   input  logic [XLEN-1:0] push_data,
   input  logic            done,
   input  logic            req_valid,
   input  logic            req_ready,
   input  logic            rsp_valid,
   input  logic            rsp_ready,
   input  logic [XLEN-1:0] rsp_rdat,
   output int              pending,
   output int              checked,
   output int              value_errs,
   output int              other_errs
);

   logic [XLEN-1:0] exp_q [$];
   logic [XLEN-1:0] expected;
   bit              rsp_was_high;
   int              since_accept;

   // sampled mid-cycle, handshakes complete at the next rising edge
   always @(negedge eai_clk) begin
      if (!arst_n) begin
         rsp_was_high = 1'b0;
         since_accept = 100;
      end else begin
         if (push) begin
            exp_q.push_back(push_data);
         end
         // accept edge registers the command, the edge after it is the earliest rise
         if (rsp_valid && !rsp_was_high && (since_accept < 1)) begin
            other_errs++;
            $display("rsp_valid rose before the second edge after the request was accepted");
         end
         if (rsp_valid && rsp_ready) begin
            if (exp_q.size() == 0) begin
               other_errs++;
               $display("a response with data %h came when none was expected", rsp_rdat);
            end else begin
               expected = exp_q.pop_front();
               checked++;
               if (rsp_rdat !== expected) begin
                  value_errs++;
                  $display("[FAIL] rsp_rdat: got %h, expected %h", rsp_rdat, expected);
               end
            end
         end
         if (req_valid && req_ready) begin
            since_accept = 0;
         end else if (since_accept < 1000) begin
            since_accept++;
         end
         rsp_was_high = rsp_valid;
         if (done && (exp_q.size() != 0)) begin
            other_errs += exp_q.size();
            $display("%0d expected responses never arrived", exp_q.size());
            exp_q.delete();
         end
         pending = exp_q.size();
      end
   end

endmodule

`default_nettype wire

// ==== eai_core_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module eai_core_tb
   import eai_pkg::*;
();

   typedef struct packed {
      logic [XLEN-1:0] inst;
      logic [XLEN-1:0] rs1;
      logic [XLEN-1:0] rs2;
      logic            has_rsp;
      logic [XLEN-1:0] exp_data;
   } case_t;

   logic            eai_clk;
   logic            arst_n;
   logic            req_valid;
   logic            req_ready;
   eai_req_t        req;
   logic            rsp_valid;
   logic            rsp_ready;
   logic [XLEN-1:0] rsp_rdat;
   logic            icb_cmd_valid;
   logic            icb_cmd_ready;
   icb_cmd_t        icb_cmd;
   logic            icb_rsp_valid;
   icb_rsp_t        icb_rsp;
   logic            mem_holdup;

   logic            push;
   logic [XLEN-1:0] push_data;
   logic            done;
   int              pending;
   int              checked;
   int              value_errs;
   int              other_errs;
   int              sva_fails;

   case_t           cases [$];
   logic [XLEN-1:0] mem_words [logic [XLEN-1:0]];
   logic [31:0]     rnd;
   int              cycles;
   int              cycle_limit = 200;

   eai_core eai_core_i (
      .eai_clk       (eai_clk),
      .arst_n        (arst_n),
      .req_valid     (req_valid),
      .req_ready     (req_ready),
      .req           (req),
      .rsp_valid     (rsp_valid),
      .rsp_ready     (rsp_ready),
      .rsp_rdat      (rsp_rdat),
      .icb_cmd_valid (icb_cmd_valid),
      .icb_cmd_ready (icb_cmd_ready),
      .icb_cmd       (icb_cmd),
      .icb_rsp_valid (icb_rsp_valid),
      .icb_rsp       (icb_rsp),
      .mem_holdup    (mem_holdup)
   );

   eai_core_checker eai_core_checker_i (
      .eai_clk    (eai_clk),
      .arst_n     (arst_n),
      .push       (push),
      .push_data  (push_data),
      .done       (done),
      .req_valid  (req_valid),
      .req_ready  (req_ready),
      .rsp_valid  (rsp_valid),
      .rsp_ready  (rsp_ready),
      .rsp_rdat   (rsp_rdat),
      .pending    (pending),
      .checked    (checked),
      .value_errs (value_errs),
      .other_errs (other_errs)
   );

   bind eai_core eai_core_sva eai_core_sva_i (
      .eai_clk       (eai_clk),
      .arst_n        (arst_n),
      .req_ready     (req_ready),
      .rsp_valid     (rsp_valid),
      .rsp_ready     (rsp_ready),
      .rsp_rdat      (rsp_rdat),
      .icb_cmd_valid (icb_cmd_valid),
      .icb_cmd_ready (icb_cmd_ready),
      .icb_cmd       (icb_cmd),
      .mem_holdup    (mem_holdup)
   );

   initial eai_clk = 1'b0;
   always #2 eai_clk = ~eai_clk;

   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic logic [XLEN-1:0] mem_read(input logic [XLEN-1:0] addr);
      if (mem_words.exists(addr)) begin
         return mem_words[addr];
      end
      // words nobody loaded
      return addr ^ 32'h5A5A_A5A5;
   endfunction

   //////////////////////////////
   // cases file
   //////////////////////////////
   initial begin : load_cases
      int              fd;
      int              n;
      string           line;
      logic [XLEN-1:0] f0;
      logic [XLEN-1:0] f1;
      logic [XLEN-1:0] f2;
      logic [XLEN-1:0] f3;
      logic [XLEN-1:0] f4;
      case_t           c;
      fd = $fopen("eai_cases.dat", "r");
      if (fd == 0) begin
         $display("could not open eai_cases.dat");
         $display("=== FAIL ===");
         $finish;
      end else begin
         while ($fgets(line, fd) != 0) begin
            n = $sscanf(line, "M %h %h", f0, f1);
            if (n == 2) begin
               mem_words[f0] = f1;
            end else begin
               n = $sscanf(line, "C %h %h %h %h %h", f0, f1, f2, f3, f4);
               if (n == 5) begin
                  c.inst     = f0;
                  c.rs1      = f1;
                  c.rs2      = f2;
                  c.has_rsp  = f3[0];
                  c.exp_data = f4;
                  cases.push_back(c);
               end
            end
         end
         $fclose(fd);
         cycle_limit = 64 * cases.size() + 200;
      end
   end

   //////////////////////////////
   // memory model
   //////////////////////////////
   initial begin : mem_model
      logic            cmd_taken;
      logic [XLEN-1:0] cmd_addr;
      logic [XLEN-1:0] rd_addr;
      logic [1:0]      rd_wait;
      logic            rd_busy;
      rnd           = 32'd91541;
      rd_busy       = 1'b0;
      rd_wait       = 2'd0;
      rd_addr       = '0;
      icb_cmd_ready = 1'b0;
      rsp_ready     = 1'b0;
      icb_rsp_valid = 1'b0;
      icb_rsp       = '0;
      forever begin
         @(negedge eai_clk);
         cmd_taken = icb_cmd_valid && icb_cmd_ready;
         cmd_addr  = icb_cmd.addr;
         @(posedge eai_clk);
         #1;
         if (icb_rsp_valid) begin
            rd_busy = 1'b0;
         end
         if (cmd_taken) begin
            rd_addr = cmd_addr;
            rd_wait = rnd[27:26];
            rd_busy = 1'b1;
         end else if (rd_busy && (rd_wait != 2'd0)) begin
            rd_wait = rd_wait - 2'd1;
         end
         rnd           = lcg_step(rnd);
         icb_cmd_ready = (rnd[31:30] != 2'd0);
         rsp_ready     = (rnd[29:28] != 2'd0);
         icb_rsp_valid = rd_busy && (rd_wait == 2'd0);
         icb_rsp.rdata = icb_rsp_valid ? mem_read(rd_addr) : '0;
      end
   end

   task automatic send_case(input case_t c);
      logic ready_seen;
      req_valid = 1'b1;
      req.inst  = c.inst;
      req.rs1   = c.rs1;
      req.rs2   = c.rs2;
      do begin
         @(negedge eai_clk);
         ready_seen = req_ready;
         @(posedge eai_clk);
      end while (!ready_seen);
      #1;
      req_valid = 1'b0;
      push      = c.has_rsp;
      push_data = c.exp_data;
      @(posedge eai_clk);
      #1;
      push = 1'b0;
   endtask

   //////////////////////////////
   // stimulus
   //////////////////////////////
   initial begin : stimulus
      req_valid = 1'b0;
      req       = '0;
      push      = 1'b0;
      push_data = '0;
      done      = 1'b0;
      arst_n    = 1'b1;
      // a real falling edge for the async reset
      #1;
      arst_n = 1'b0;
      repeat (16) @(posedge eai_clk);
      #1;
      arst_n = 1'b1;
      foreach (cases[i]) begin
         send_case(cases[i]);
      end
      while (pending != 0) begin
         @(posedge eai_clk);
         #1;
      end
      // room for a stray response
      repeat (8) @(posedge eai_clk);
      #1;
      done = 1'b1;
      @(posedge eai_clk);
      #1;
      done      = 1'b0;
      sva_fails = eai_core_i.eai_core_sva_i.fail_count;
      $display("checked %0d responses, %0d value errors, %0d other errors, %0d assertion failures",
               checked, value_errs, other_errs, sva_fails);
      if ((value_errs + other_errs + sva_fails) == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

   always @(posedge eai_clk) begin
      cycles++;
      if (cycles > cycle_limit) begin
         $display("run did not finish within %0d cycles", cycle_limit);
         $display("=== FAIL ===");
         $finish;
      end
   end

endmodule

`default_nettype wire

// ==== eai_cases.dat ====
# M addr data                       : memory word preload, hex
# C inst rs1 rs2 rsp expected      : command, rsp is 1 when a response is due
M 00000100 00000001
M 00000104 00000002
M 00000108 00000003
M 0000010C 00000010
M 00000110 00000020
M 00000114 00000030
M 00000118 FFFFFFF0
M 0000011C 00000100
M 00000120 80000000
C 0000300B 00000100 00000003 1 00000000
C 0200600B 00000000 00000000 1 00000006
C 0200600B 00000001 00000000 1 00000060
C 0200600B 00000002 00000000 1 800000F0
C 0400600B 00000000 00000000 1 00000001
C 0400600B 00000001 00000000 1 00000122
C 0400600B 00000002 00000000 1 80000033
C 0400600B 00000003 00000000 1 00000000
C 0400600B FFFFFFFF 00000000 1 00000000
C 0600600B 00000001 00000000 0 00000000
C 00000033 00000000 00000000 0 00000000
C 0400600B 00000001 00000000 1 00000122
C 0200600B 00000000 00000000 1 00000006
C 0400600B 00000002 00000000 1 00000003
C 0000300B 00000104 00000001 1 00000000
C 0200600B 00000001 00000000 1 00000033
C 0400600B 00000001 00000000 1 00000012

// ==== list.f ====
eai_pkg.sv
eai_decode.sv
eai_execute.sv
eai_result.sv
eai_core.sv
eai_core_sva.sv
eai_core_checker.sv
eai_core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= eai_core_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= === PASS ===

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
